/* compile.f */
+incdir+rtl
rtl/id_pkg.sv
rtl/id_decoder.sv
rtl/id_operand_mux.sv
rtl/id_branch_unit.sv
rtl/id_ex_reg.sv
rtl/id_stage.sv
verification/id_stage_tb.sv

/* rtl/id_branch_unit.sv */
`include "id_settings.svh"

module id_branch_unit (
    input  id_pkg::word_t    pc_i,
    input  id_pkg::inst_u    inst_i,
    input  id_pkg::br_kind_e br_kind_i,
    input  logic             link_i,
    input  id_pkg::word_t    opnd1_i,
    input  id_pkg::word_t    opnd2_i,
    output logic             taken_o,
    output id_pkg::word_t    target_o,
    output id_pkg::word_t    return_addr_o
);

    id_pkg::word_t                pc_plus_1;
    id_pkg::word_t                br_offset;
    id_pkg::word_t                jump_target;
    logic signed [`ID_WORD_W-1:0] opnd1_s;

    assign pc_plus_1   = pc_i + 1'b1;       // word addressed pc
    assign br_offset   = {{(`ID_WORD_W-`ID_IMM_W){inst_i.i.imm16[`ID_IMM_W-1]}},
                          inst_i.i.imm16};
    assign jump_target = {{(`ID_WORD_W-`ID_INDEX_W){1'b0}}, inst_i.j.index26};
    assign opnd1_s     = opnd1_i;

    always_comb begin
        case (br_kind_i)
            id_pkg::BR_JUMP_IMM,
            id_pkg::BR_JUMP_REG: taken_o = 1'b1;
            id_pkg::BR_EQ:       taken_o = (opnd1_i == opnd2_i);
            id_pkg::BR_NE:       taken_o = (opnd1_i != opnd2_i);
            id_pkg::BR_LEZ:      taken_o = (opnd1_s <= 0);
            id_pkg::BR_GTZ:      taken_o = (opnd1_s > 0);
            id_pkg::BR_LTZ:      taken_o = (opnd1_s < 0);
            id_pkg::BR_GEZ:      taken_o = (opnd1_s >= 0);
            default:             taken_o = 1'b0;
        endcase
    end

    always_comb begin
        if (!taken_o) begin
            target_o = '0;
        end else if (br_kind_i == id_pkg::BR_JUMP_IMM) begin
            target_o = jump_target;
        end else if (br_kind_i == id_pkg::BR_JUMP_REG) begin
            target_o = opnd1_i;             // already forwarded
        end else begin
            target_o = pc_plus_1 + br_offset;
        end
    end

    // linking forms return to pc+1 even when not taken
    assign return_addr_o = link_i ? pc_plus_1 : '0;

endmodule

/* rtl/id_decoder.sv */
`include "id_settings.svh"

module id_decoder (
    input  id_pkg::inst_u      inst_i,
    output id_pkg::rd_req_t    rd_req1_o,
    output id_pkg::rd_req_t    rd_req2_o,
    output id_pkg::word_t      imm_o,
    output id_pkg::ex_bundle_t dec_o,
    output id_pkg::br_kind_e   br_kind_o,
    output logic               link_o
);

    // SPECIAL funct to alu operation, both shift forms share one op
    function automatic id_pkg::aluop_e funct_aluop(input logic [`ID_OP_W-1:0] funct);
        id_pkg::aluop_e op;
        case (funct)
            `ID_FN_AND:              op = id_pkg::ALUOP_AND;
            `ID_FN_OR:               op = id_pkg::ALUOP_OR;
            `ID_FN_XOR:              op = id_pkg::ALUOP_XOR;
            `ID_FN_NOR:              op = id_pkg::ALUOP_NOR;
            `ID_FN_SLL, `ID_FN_SLLV: op = id_pkg::ALUOP_SLL;
            `ID_FN_SRL, `ID_FN_SRLV: op = id_pkg::ALUOP_SRL;
            `ID_FN_SRA, `ID_FN_SRAV: op = id_pkg::ALUOP_SRA;
            default:                 op = id_pkg::ALUOP_NOP;
        endcase
        return op;
    endfunction

    always_comb begin
        rd_req1_o = '0;                     // unknown encodings stay NOP
        rd_req2_o = '0;
        imm_o     = '0;
        dec_o     = '0;
        br_kind_o = id_pkg::BR_NONE;
        link_o    = 1'b0;

        case (inst_i.r.op)
            `ID_OP_SPECIAL: begin
                case (inst_i.r.funct)
                    `ID_FN_AND, `ID_FN_OR, `ID_FN_XOR, `ID_FN_NOR: begin
                        if (inst_i.r.sa == '0) begin
                            dec_o.aluop  = funct_aluop(inst_i.r.funct);
                            dec_o.alusel = id_pkg::ALUSEL_LOGIC;
                            dec_o.we     = 1'b1;
                            dec_o.waddr  = inst_i.r.rd;
                            rd_req1_o    = '{re: 1'b1, raddr: inst_i.r.rs};
                            rd_req2_o    = '{re: 1'b1, raddr: inst_i.r.rt};
                        end
                    end
                    `ID_FN_SLLV, `ID_FN_SRLV, `ID_FN_SRAV: begin
                        if (inst_i.r.sa == '0) begin
                            dec_o.aluop  = funct_aluop(inst_i.r.funct);
                            dec_o.alusel = id_pkg::ALUSEL_SHIFT;
                            dec_o.we     = 1'b1;
                            dec_o.waddr  = inst_i.r.rd;
                            rd_req1_o    = '{re: 1'b1, raddr: inst_i.r.rs};
                            rd_req2_o    = '{re: 1'b1, raddr: inst_i.r.rt};
                        end
                    end
                    `ID_FN_SLL, `ID_FN_SRL, `ID_FN_SRA: begin
                        if (inst_i.r.rs == '0) begin
                            dec_o.aluop  = funct_aluop(inst_i.r.funct);
                            dec_o.alusel = id_pkg::ALUSEL_SHIFT;
                            dec_o.we     = 1'b1;
                            dec_o.waddr  = inst_i.r.rd;
                            rd_req2_o    = '{re: 1'b1, raddr: inst_i.r.rt};
                            imm_o = {{(`ID_WORD_W-`ID_REG_AW){1'b0}}, inst_i.r.sa}; // sa to opnd1
                        end
                    end
                    `ID_FN_JR: begin
                        if (inst_i.r.sa == '0) begin
                            dec_o.aluop  = id_pkg::ALUOP_JR;
                            dec_o.alusel = id_pkg::ALUSEL_JUMP_BRANCH;
                            rd_req1_o    = '{re: 1'b1, raddr: inst_i.r.rs};
                            br_kind_o    = id_pkg::BR_JUMP_REG;
                        end
                    end
                    `ID_FN_JALR: begin
                        if (inst_i.r.sa == '0) begin
                            dec_o.aluop  = id_pkg::ALUOP_JALR;
                            dec_o.alusel = id_pkg::ALUSEL_JUMP_BRANCH;
                            dec_o.we     = 1'b1;
                            dec_o.waddr  = (inst_i.r.rd == '0) ? `ID_LINK_REG : inst_i.r.rd;
                            rd_req1_o    = '{re: 1'b1, raddr: inst_i.r.rs};
                            br_kind_o    = id_pkg::BR_JUMP_REG;
                            link_o       = 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
            `ID_OP_ANDI, `ID_OP_ORI, `ID_OP_XORI: begin
                case (inst_i.i.op)
                    `ID_OP_ANDI: dec_o.aluop = id_pkg::ALUOP_AND;
                    `ID_OP_ORI:  dec_o.aluop = id_pkg::ALUOP_OR;
                    default:     dec_o.aluop = id_pkg::ALUOP_XOR;
                endcase
                dec_o.alusel = id_pkg::ALUSEL_LOGIC;
                dec_o.we     = 1'b1;
                dec_o.waddr  = inst_i.i.rt;
                rd_req1_o    = '{re: 1'b1, raddr: inst_i.i.rs};
                imm_o = {{(`ID_WORD_W-`ID_IMM_W){1'b0}}, inst_i.i.imm16}; // zero extend
            end
            `ID_OP_LUI: begin
                dec_o.aluop  = id_pkg::ALUOP_OR;    // or with zero upper imm
                dec_o.alusel = id_pkg::ALUSEL_LOGIC;
                dec_o.we     = 1'b1;
                dec_o.waddr  = inst_i.i.rt;
                imm_o = {inst_i.i.imm16, {(`ID_WORD_W-`ID_IMM_W){1'b0}}};
            end
            `ID_OP_J, `ID_OP_JAL: begin
                dec_o.alusel = id_pkg::ALUSEL_JUMP_BRANCH;
                br_kind_o    = id_pkg::BR_JUMP_IMM;
                if (inst_i.j.op == `ID_OP_JAL) begin
                    dec_o.aluop = id_pkg::ALUOP_JALR;
                    dec_o.we    = 1'b1;
                    dec_o.waddr = `ID_LINK_REG;
                    link_o      = 1'b1;
                end else begin
                    dec_o.aluop = id_pkg::ALUOP_JR;
                end
            end
            `ID_OP_BEQ, `ID_OP_BNE: begin
                dec_o.aluop  = id_pkg::ALUOP_JR;
                dec_o.alusel = id_pkg::ALUSEL_JUMP_BRANCH;
                rd_req1_o    = '{re: 1'b1, raddr: inst_i.i.rs};
                rd_req2_o    = '{re: 1'b1, raddr: inst_i.i.rt};
                br_kind_o = (inst_i.i.op == `ID_OP_BEQ) ? id_pkg::BR_EQ : id_pkg::BR_NE;
            end
            `ID_OP_BLEZ, `ID_OP_BGTZ: begin
                dec_o.aluop  = id_pkg::ALUOP_JR;
                dec_o.alusel = id_pkg::ALUSEL_JUMP_BRANCH;
                rd_req1_o    = '{re: 1'b1, raddr: inst_i.i.rs};
                br_kind_o = (inst_i.i.op == `ID_OP_BLEZ) ? id_pkg::BR_LEZ : id_pkg::BR_GTZ;
            end
            `ID_OP_REGIMM: begin
                case (inst_i.i.rt)
                    `ID_RI_BLTZ, `ID_RI_BGEZ, `ID_RI_BLTZAL, `ID_RI_BGEZAL: begin
                        dec_o.alusel = id_pkg::ALUSEL_JUMP_BRANCH;
                        rd_req1_o    = '{re: 1'b1, raddr: inst_i.i.rs};
                        // bit 0 of the code picks ge over lt
                        br_kind_o = inst_i.i.rt[0] ? id_pkg::BR_GEZ : id_pkg::BR_LTZ;
                        if (inst_i.i.rt[4]) begin   // linking forms
                            dec_o.aluop = id_pkg::ALUOP_JALR;
                            dec_o.we    = 1'b1;
                            dec_o.waddr = `ID_LINK_REG;
                            link_o      = 1'b1;
                        end else begin
                            dec_o.aluop = id_pkg::ALUOP_JR;
                        end
                    end
                    default: begin
                    end
                endcase
            end
            default: begin
            end
        endcase
    end

endmodule

/* rtl/id_ex_reg.sv */
module id_ex_reg (
    input  logic               clk,
    input  logic               rst_n_i,
    input  id_pkg::ex_bundle_t bundle_i,
    output id_pkg::ex_bundle_t bundle_o
);

    // all zero is the NOP bundle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bundle_o <= '0;
        end else begin
            bundle_o <= bundle_i;           // new instruction every cycle
        end
    end

endmodule

/* rtl/id_operand_mux.sv */
module id_operand_mux (
    input  id_pkg::rd_req_t req_i,
    input  id_pkg::word_t   rf_data_i,
    input  id_pkg::word_t   imm_i,
    input  id_pkg::fwd_t    ex_fwd_i,
    input  id_pkg::fwd_t    mem_fwd_i,
    output id_pkg::word_t   opnd_o
);

    logic ex_hit;
    logic mem_hit;

    // register 0 gets no special treatment here
    assign ex_hit  = req_i.re && ex_fwd_i.we && (ex_fwd_i.waddr == req_i.raddr);
    assign mem_hit = req_i.re && mem_fwd_i.we && (mem_fwd_i.waddr == req_i.raddr);

    always_comb begin
        if (ex_hit) begin
            opnd_o = ex_fwd_i.wdata;        // youngest result wins
        end else if (mem_hit) begin
            opnd_o = mem_fwd_i.wdata;
        end else if (req_i.re) begin
            opnd_o = rf_data_i;
        end else begin
            opnd_o = imm_i;                 // no read, use immediate
        end
    end

endmodule

/* rtl/id_pkg.sv */
`include "id_settings.svh"

package id_pkg;

    typedef logic [`ID_WORD_W-1:0] word_t;
    typedef logic [`ID_REG_AW-1:0] reg_addr_t;

    typedef struct packed {
        logic [`ID_OP_W-1:0]   op;
        reg_addr_t             rs;
        reg_addr_t             rt;
        reg_addr_t             rd;
        logic [`ID_REG_AW-1:0] sa;       // shift amount
        logic [`ID_OP_W-1:0]   funct;
    } r_fields_t;

    typedef struct packed {
        logic [`ID_OP_W-1:0]   op;
        reg_addr_t             rs;
        reg_addr_t             rt;       // also the REGIMM code
        logic [`ID_IMM_W-1:0]  imm16;
    } i_fields_t;

    typedef struct packed {
        logic [`ID_OP_W-1:0]    op;
        logic [`ID_INDEX_W-1:0] index26;
    } j_fields_t;

    // one instruction word, three field layouts
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } inst_u;

    typedef enum logic [`ID_ALUOP_W-1:0] {
        ALUOP_NOP  = 8'b00000000,
        ALUOP_AND  = 8'b00100100,
        ALUOP_OR   = 8'b00100101,
        ALUOP_XOR  = 8'b00100110,
        ALUOP_NOR  = 8'b00100111,
        ALUOP_SLL  = 8'b01111100,
        ALUOP_SRL  = 8'b00000010,
        ALUOP_SRA  = 8'b00000011,
        ALUOP_JR   = 8'b00001000,
        ALUOP_JALR = 8'b00001001
    } aluop_e;

    typedef enum logic [`ID_ALUSEL_W-1:0] {
        ALUSEL_NOP         = 3'b000,
        ALUSEL_LOGIC       = 3'b001,
        ALUSEL_SHIFT       = 3'b010,
        ALUSEL_JUMP_BRANCH = 3'b110
    } alusel_e;

    typedef enum logic [`ID_BRKIND_W-1:0] {
        BR_NONE, BR_JUMP_IMM, BR_JUMP_REG,
        BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
    } br_kind_e;

    // pending write from a later stage
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } fwd_t;

    typedef struct packed {
        logic      re;
        reg_addr_t raddr;
    } rd_req_t;

    typedef struct packed {
        aluop_e    aluop;
        alusel_e   alusel;
        word_t     opnd1;
        word_t     opnd2;
        logic      we;
        reg_addr_t waddr;
        word_t     return_addr;
    } ex_bundle_t;

endpackage

/* rtl/id_settings.svh */
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

`define ID_WORD_W       32          // data and pc width
`define ID_REG_AW       5           // register address width
`define ID_OP_W         6           // opcode and funct width
`define ID_IMM_W        16
`define ID_INDEX_W      26          // jump index field
`define ID_ALUOP_W      8
`define ID_ALUSEL_W     3
`define ID_BRKIND_W     4

`define ID_LINK_REG     5'd31       // $ra

// primary opcodes
`define ID_OP_SPECIAL   6'b000000
`define ID_OP_REGIMM    6'b000001
`define ID_OP_J         6'b000010
`define ID_OP_JAL       6'b000011
`define ID_OP_BEQ       6'b000100
`define ID_OP_BNE       6'b000101
`define ID_OP_BLEZ      6'b000110
`define ID_OP_BGTZ      6'b000111
`define ID_OP_ANDI      6'b001100
`define ID_OP_ORI       6'b001101
`define ID_OP_XORI      6'b001110
`define ID_OP_LUI       6'b001111

// SPECIAL function codes
`define ID_FN_SLL       6'b000000
`define ID_FN_SRL       6'b000010
`define ID_FN_SRA       6'b000011
`define ID_FN_SLLV      6'b000100
`define ID_FN_SRLV      6'b000110
`define ID_FN_SRAV      6'b000111
`define ID_FN_JR        6'b001000
`define ID_FN_JALR      6'b001001
`define ID_FN_AND       6'b100100
`define ID_FN_OR        6'b100101
`define ID_FN_XOR       6'b100110
`define ID_FN_NOR       6'b100111

// REGIMM codes, carried in rt
`define ID_RI_BLTZ      5'b00000
`define ID_RI_BGEZ      5'b00001
`define ID_RI_BLTZAL    5'b10000
`define ID_RI_BGEZAL    5'b10001

`endif

/* rtl/id_stage.sv */
module id_stage (
    input  logic               clk,
    input  logic               rst_n_i,
    input  id_pkg::word_t      pc_i,
    input  id_pkg::inst_u      inst_i,
    input  id_pkg::word_t      rdata1_i,
    input  id_pkg::word_t      rdata2_i,
    input  id_pkg::fwd_t       ex_fwd_i,
    input  id_pkg::fwd_t       mem_fwd_i,
    output id_pkg::rd_req_t    rd_req1_o,
    output id_pkg::rd_req_t    rd_req2_o,
    output logic               branch_taken_o,
    output id_pkg::word_t      branch_target_o,
    output id_pkg::ex_bundle_t ex_o
);

    id_pkg::word_t      imm;
    id_pkg::ex_bundle_t dec;
    id_pkg::br_kind_e   br_kind;
    logic               link;
    id_pkg::word_t      opnd1;
    id_pkg::word_t      opnd2;
    id_pkg::word_t      return_addr;
    id_pkg::ex_bundle_t ex_d;

    id_decoder decoder0 (
        .inst_i    (inst_i),
        .rd_req1_o (rd_req1_o),
        .rd_req2_o (rd_req2_o),
        .imm_o     (imm),
        .dec_o     (dec),
        .br_kind_o (br_kind),
        .link_o    (link)
    );

    id_operand_mux opnd1_mux (
        .req_i     (rd_req1_o),
        .rf_data_i (rdata1_i),
        .imm_i     (imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .opnd_o    (opnd1)
    );

    id_operand_mux opnd2_mux (
        .req_i     (rd_req2_o),
        .rf_data_i (rdata2_i),
        .imm_i     (imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .opnd_o    (opnd2)
    );

    id_branch_unit branch0 (
        .pc_i          (pc_i),
        .inst_i        (inst_i),
        .br_kind_i     (br_kind),
        .link_i        (link),
        .opnd1_i       (opnd1),
        .opnd2_i       (opnd2),
        .taken_o       (branch_taken_o),
        .target_o      (branch_target_o),
        .return_addr_o (return_addr)
    );

    // decoder controls plus datapath fields
    always_comb begin
        ex_d             = dec;
        ex_d.opnd1       = opnd1;
        ex_d.opnd2       = opnd2;
        ex_d.return_addr = return_addr;
    end

    id_ex_reg ex_reg0 (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .bundle_i (ex_d),
        .bundle_o (ex_o)
    );

endmodule

/* run.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator
verilator --binary --timing --assert -f compile.f --top-module id_stage_tb -o id_sim \
    > build.log 2>&1 \
    && ./obj_dir/id_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
grep -q "Finished with errors" sim.log \
    && { echo "simulation FAILED, see sim.log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

/* verification/id_stage_tb.sv */
`include "id_settings.svh"

module id_stage_tb;

    typedef struct packed {
        id_pkg::ex_bundle_t b;
        id_pkg::rd_req_t    req1;
        id_pkg::rd_req_t    req2;
        logic               taken;
        id_pkg::word_t      target;
    } ref_t;

    logic               clk;
    logic               rst_n_i;
    id_pkg::word_t      pc;
    id_pkg::inst_u      inst;
    id_pkg::word_t      rdata1;
    id_pkg::word_t      rdata2;
    id_pkg::fwd_t       ex_fwd;
    id_pkg::fwd_t       mem_fwd;
    id_pkg::rd_req_t    rd_req1;
    id_pkg::rd_req_t    rd_req2;
    logic               taken;
    id_pkg::word_t      target;
    id_pkg::ex_bundle_t ex;
    id_pkg::ex_bundle_t exp_q;              // expected bundle, one cycle late
    ref_t               cur;
    ref_t               nxt;                // decode of the inputs before the edge
    id_pkg::word_t      rf [32];
    int                 errors;
    int                 checks;

    assign rdata1 = rf[rd_req1.raddr];      // register file answers at once
    assign rdata2 = rf[rd_req2.raddr];

    id_stage dut0 (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .pc_i            (pc),
        .inst_i          (inst),
        .rdata1_i        (rdata1),
        .rdata2_i        (rdata2),
        .ex_fwd_i        (ex_fwd),
        .mem_fwd_i       (mem_fwd),
        .rd_req1_o       (rd_req1),
        .rd_req2_o       (rd_req2),
        .branch_taken_o  (taken),
        .branch_target_o (target),
        .ex_o            (ex)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic id_pkg::word_t operand(input logic re, input id_pkg::reg_addr_t a,
                                              input id_pkg::word_t imm,
                                              input id_pkg::fwd_t exf, input id_pkg::fwd_t memf);
        if (re && exf.we && exf.waddr == a) return exf.wdata;
        else if (re && memf.we && memf.waddr == a) return memf.wdata;
        else if (re) return rf[a];
        else return imm;
    endfunction

    // expected outputs straight from the instruction bits
    function automatic ref_t ref_decode(input id_pkg::word_t w, input id_pkg::word_t pc_v,
                                        input id_pkg::fwd_t exf, input id_pkg::fwd_t memf);
        ref_t               r;
        logic [5:0]         op;
        logic [5:0]         fn;
        id_pkg::reg_addr_t  rs;
        id_pkg::reg_addr_t  rt;
        id_pkg::reg_addr_t  rd;
        id_pkg::reg_addr_t  sa;
        logic [15:0]        imm16;
        logic               re1;
        logic               re2;
        logic               link;
        id_pkg::word_t      imm;
        id_pkg::word_t      o1;
        id_pkg::word_t      o2;
        id_pkg::word_t      pc1;
        id_pkg::br_kind_e   kind;
        op = w[31:26];
        rs = w[25:21];
        rt = w[20:16];
        rd = w[15:11];
        sa = w[10:6];
        fn = w[5:0];
        imm16 = w[15:0];
        r = '0;
        re1 = 1'b0;
        re2 = 1'b0;
        link = 1'b0;
        imm = '0;
        kind = id_pkg::BR_NONE;
        case (op)
            `ID_OP_SPECIAL: begin
                if (fn inside {`ID_FN_AND, `ID_FN_OR, `ID_FN_XOR, `ID_FN_NOR} && sa == 0) begin
                    case (fn)
                        `ID_FN_AND: r.b.aluop = id_pkg::ALUOP_AND;
                        `ID_FN_OR:  r.b.aluop = id_pkg::ALUOP_OR;
                        `ID_FN_XOR: r.b.aluop = id_pkg::ALUOP_XOR;
                        default:    r.b.aluop = id_pkg::ALUOP_NOR;
                    endcase
                    r.b.alusel = id_pkg::ALUSEL_LOGIC;
                    {r.b.we, r.b.waddr, re1, re2} = {1'b1, rd, 2'b11};
                end else if (fn inside {`ID_FN_SLLV, `ID_FN_SRLV, `ID_FN_SRAV} && sa == 0) begin
                    r.b.aluop = (fn == `ID_FN_SLLV) ? id_pkg::ALUOP_SLL :
                                (fn == `ID_FN_SRLV) ? id_pkg::ALUOP_SRL : id_pkg::ALUOP_SRA;
                    r.b.alusel = id_pkg::ALUSEL_SHIFT;
                    {r.b.we, r.b.waddr, re1, re2} = {1'b1, rd, 2'b11};
                end else if (fn inside {`ID_FN_SLL, `ID_FN_SRL, `ID_FN_SRA} && rs == 0) begin
                    r.b.aluop = (fn == `ID_FN_SLL) ? id_pkg::ALUOP_SLL :
                                (fn == `ID_FN_SRL) ? id_pkg::ALUOP_SRL : id_pkg::ALUOP_SRA;
                    r.b.alusel = id_pkg::ALUSEL_SHIFT;
                    {r.b.we, r.b.waddr, re2} = {1'b1, rd, 1'b1};
                    imm = {27'b0, sa};
                end else if ((fn == `ID_FN_JR || fn == `ID_FN_JALR) && sa == 0) begin
                    r.b.alusel = id_pkg::ALUSEL_JUMP_BRANCH;
                    re1 = 1'b1;
                    kind = id_pkg::BR_JUMP_REG;
                    r.b.aluop = id_pkg::ALUOP_JR;
                    if (fn == `ID_FN_JALR) begin
                        r.b.aluop = id_pkg::ALUOP_JALR;
                        r.b.we = 1'b1;
                        r.b.waddr = (rd == 0) ? `ID_LINK_REG : rd;
                        link = 1'b1;
                    end
                end
            end
            `ID_OP_ANDI, `ID_OP_ORI, `ID_OP_XORI, `ID_OP_LUI: begin
                r.b.aluop = (op == `ID_OP_ANDI) ? id_pkg::ALUOP_AND :
                            (op == `ID_OP_XORI) ? id_pkg::ALUOP_XOR : id_pkg::ALUOP_OR;
                r.b.alusel = id_pkg::ALUSEL_LOGIC;
                {r.b.we, r.b.waddr} = {1'b1, rt};
                re1 = (op != `ID_OP_LUI);
                imm = (op == `ID_OP_LUI) ? {imm16, 16'b0} : {16'b0, imm16};
            end
            `ID_OP_J, `ID_OP_JAL: begin
                r.b.alusel = id_pkg::ALUSEL_JUMP_BRANCH;
                kind = id_pkg::BR_JUMP_IMM;
                r.b.aluop = id_pkg::ALUOP_JR;
                if (op == `ID_OP_JAL) begin
                    r.b.aluop = id_pkg::ALUOP_JALR;
                    {r.b.we, r.b.waddr, link} = {1'b1, `ID_LINK_REG, 1'b1};
                end
            end
            `ID_OP_BEQ, `ID_OP_BNE, `ID_OP_BLEZ, `ID_OP_BGTZ: begin
                r.b.aluop = id_pkg::ALUOP_JR;
                r.b.alusel = id_pkg::ALUSEL_JUMP_BRANCH;
                re1 = 1'b1;
                re2 = (op == `ID_OP_BEQ || op == `ID_OP_BNE);
                kind = (op == `ID_OP_BEQ) ? id_pkg::BR_EQ : (op == `ID_OP_BNE) ? id_pkg::BR_NE :
                       (op == `ID_OP_BLEZ) ? id_pkg::BR_LEZ : id_pkg::BR_GTZ;
            end
            `ID_OP_REGIMM: begin
                if (rt inside {`ID_RI_BLTZ, `ID_RI_BGEZ, `ID_RI_BLTZAL, `ID_RI_BGEZAL}) begin
                    r.b.alusel = id_pkg::ALUSEL_JUMP_BRANCH;
                    re1 = 1'b1;
                    kind = (rt == `ID_RI_BGEZ || rt == `ID_RI_BGEZAL) ? id_pkg::BR_GEZ
                                                                       : id_pkg::BR_LTZ;
                    r.b.aluop = id_pkg::ALUOP_JR;
                    if (rt == `ID_RI_BLTZAL || rt == `ID_RI_BGEZAL) begin
                        r.b.aluop = id_pkg::ALUOP_JALR;
                        {r.b.we, r.b.waddr, link} = {1'b1, `ID_LINK_REG, 1'b1};
                    end
                end
            end
            default: begin
            end
        endcase
        r.req1.re = re1;
        r.req1.raddr = rs;
        r.req2.re = re2;
        r.req2.raddr = rt;
        o1 = operand(re1, rs, imm, exf, memf);
        o2 = operand(re2, rt, imm, exf, memf);
        pc1 = pc_v + 32'd1;
        r.b.opnd1 = o1;
        r.b.opnd2 = o2;
        r.b.return_addr = link ? pc1 : '0;
        case (kind)
            id_pkg::BR_JUMP_IMM, id_pkg::BR_JUMP_REG: r.taken = 1'b1;
            id_pkg::BR_EQ:  r.taken = (o1 == o2);
            id_pkg::BR_NE:  r.taken = (o1 != o2);
            id_pkg::BR_LEZ: r.taken = ($signed(o1) <= 0);
            id_pkg::BR_GTZ: r.taken = ($signed(o1) > 0);
            id_pkg::BR_LTZ: r.taken = ($signed(o1) < 0);
            id_pkg::BR_GEZ: r.taken = ($signed(o1) >= 0);
            default:        r.taken = 1'b0;
        endcase
        if (!r.taken) r.target = '0;
        else if (kind == id_pkg::BR_JUMP_IMM) r.target = {6'b0, w[25:0]};
        else if (kind == id_pkg::BR_JUMP_REG) r.target = o1;
        else r.target = pc1 + {{16{imm16[15]}}, imm16};
        return r;
    endfunction

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exp_q <= '0;
        end else begin
            nxt = ref_decode(inst, pc, ex_fwd, mem_fwd);  // inputs before the edge
            exp_q <= nxt.b;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        cur = ref_decode(inst, pc, ex_fwd, mem_fwd);
        checks++;
        assert (ex === exp_q) else begin
            errors++;
            $display("MISMATCH ex_o expected %h got %h", exp_q, ex);
        end
        assert (taken === cur.taken) else begin
            errors++;
            $display("MISMATCH branch_taken_o expected %h got %h", cur.taken, taken);
        end
        assert (target === cur.target) else begin
            errors++;
            $display("MISMATCH branch_target_o expected %h got %h", cur.target, target);
        end
        assert (rd_req1.re === cur.req1.re &&
                (!cur.req1.re || rd_req1.raddr === cur.req1.raddr)) else begin
            errors++;
            $display("MISMATCH rd_req1_o expected %h got %h", cur.req1, rd_req1);
        end
        assert (rd_req2.re === cur.req2.re &&
                (!cur.req2.re || rd_req2.raddr === cur.req2.raddr)) else begin
            errors++;
            $display("MISMATCH rd_req2_o expected %h got %h", cur.req2, rd_req2);
        end
        assert (inst !== '0 || taken === 1'b0) else begin
            errors++;
            $display("MISMATCH branch_taken_o on NOP expected 0 got %h", taken);
        end
    end

    function automatic id_pkg::word_t pick_val();
        case ($urandom % 6)
            0:       return 32'h0;
            1:       return 32'h1;
            2:       return 32'hffff_ffff;
            3:       return 32'h8000_0000;
            default: return $urandom;
        endcase
    endfunction

    function automatic id_pkg::reg_addr_t rand_reg();
        id_pkg::word_t t;
        t = $urandom;
        return t[4:0];
    endfunction

    // write port that often hits one of the read addresses
    function automatic id_pkg::fwd_t rand_fwd(input id_pkg::reg_addr_t rs,
                                              input id_pkg::reg_addr_t rt);
        id_pkg::fwd_t f;
        f.we = ($urandom % 2 == 0);
        case ($urandom % 3)
            0:       f.waddr = rs;
            1:       f.waddr = rt;
            default: f.waddr = rand_reg();
        endcase
        f.wdata = pick_val();
        return f;
    endfunction

    task automatic issue(input id_pkg::word_t w);
        id_pkg::word_t v;
        @(posedge clk);
        v = pick_val();
        inst <= w;
        pc <= $urandom;
        rf[w[25:21]] <= v;
        if ($urandom % 4 == 0) rf[w[20:16]] <= v;      // equal operands
        else rf[w[20:16]] <= pick_val();
        ex_fwd <= rand_fwd(w[25:21], w[20:16]);
        mem_fwd <= rand_fwd(w[25:21], w[20:16]);
    endtask

    initial begin
        int            i;
        id_pkg::word_t t;
        logic [5:0]    fn;
        id_pkg::reg_addr_t sa;
        void'($urandom(32'hbe19));
        errors = 0;
        checks = 0;
        rst_n_i = 1'b0;
        inst = '0;
        pc = '0;
        ex_fwd = '0;
        mem_fwd = '0;
        for (i = 0; i < 32; i++) rf[i] = 32'h9e37_79b9 * (i + 1);
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        for (i = 0; i < 150; i++) begin           // logic ops
            t = $urandom;
            sa = ($urandom % 6 == 0) ? rand_reg() : 5'd0;
            case ($urandom % 8)
                0: fn = `ID_FN_AND;
                1: fn = `ID_FN_OR;
                2: fn = `ID_FN_XOR;
                3: fn = `ID_FN_NOR;
                default: fn = 6'h3f;
            endcase
            if (fn != 6'h3f) issue({`ID_OP_SPECIAL, t[25:11], sa, fn});
            else issue({2'b00, 2'b11, t[27:0]});   // ANDI, ORI, XORI, LUI
        end
        for (i = 0; i < 150; i++) begin           // shifts
            t = $urandom;
            sa = ($urandom % 4 == 0) ? 5'd0 : rand_reg();
            case ($urandom % 6)
                0: issue({`ID_OP_SPECIAL, t[25:11], ($urandom % 4 == 0) ? sa : 5'd0, `ID_FN_SLLV});
                1: issue({`ID_OP_SPECIAL, t[25:11], ($urandom % 4 == 0) ? sa : 5'd0, `ID_FN_SRLV});
                2: issue({`ID_OP_SPECIAL, t[25:11], ($urandom % 4 == 0) ? sa : 5'd0, `ID_FN_SRAV});
                3: issue({`ID_OP_SPECIAL, 5'd0, t[20:11], sa, `ID_FN_SLL});
                4: issue({`ID_OP_SPECIAL, 5'd0, t[20:11], sa, `ID_FN_SRL});
                default: issue({`ID_OP_SPECIAL, ($urandom % 6 == 0) ? t[25:21] : 5'd0,
                                t[20:11], sa, `ID_FN_SRA});
            endcase
        end
        for (i = 0; i < 300; i++) begin           // branches
            t = $urandom;
            case ($urandom % 8)
                0: issue({`ID_OP_BEQ, t[25:0]});
                1: issue({`ID_OP_BNE, t[25:0]});
                2: issue({`ID_OP_BLEZ, t[25:0]});
                3: issue({`ID_OP_BGTZ, t[25:0]});
                4: issue({`ID_OP_REGIMM, t[25:21], `ID_RI_BLTZ, t[15:0]});
                5: issue({`ID_OP_REGIMM, t[25:21], `ID_RI_BGEZ, t[15:0]});
                6: issue({`ID_OP_REGIMM, t[25:21], `ID_RI_BLTZAL, t[15:0]});
                default: issue({`ID_OP_REGIMM, t[25:21], `ID_RI_BGEZAL, t[15:0]});
            endcase
        end
        for (i = 0; i < 150; i++) begin           // jumps and unknown encodings
            t = $urandom;
            case ($urandom % 6)
                0: issue({`ID_OP_J, t[25:0]});
                1: issue({`ID_OP_JAL, t[25:0]});
                2: issue({`ID_OP_SPECIAL, t[25:11], 5'd0, `ID_FN_JR});
                3: issue({`ID_OP_SPECIAL, t[25:16], ($urandom % 2 == 0) ? 5'd0 : t[15:11],
                          5'd0, `ID_FN_JALR});
                4: issue({6'b100011, t[25:0]});
                default: issue(t);
            endcase
        end
        issue('0);
        repeat (2) @(posedge clk);                // one cycle latency, then the last check
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
